//--- cluster_periph_pkg.sv
/*
  Shared types and address map of the cluster peripheral.
  Byte addresses are 8 bits wide and word aligned; at most 8 performance counters.
*/
`default_nettype none

package cluster_periph_pkg;

  localparam int unsigned CntWidth = 48;

  // Register map.
  localparam logic [7:0] EnAddr         = 8'h00;
  localparam logic [7:0] ClintSetAddr   = 8'h04;
  localparam logic [7:0] ClintClearAddr = 8'h08;
  localparam logic [7:0] ClintStateAddr = 8'h0C;
  localparam logic [7:0] PrefetchAddr   = 8'h10;
  localparam logic [7:0] HartBaseAddr   = 8'h14;
  // One word per counter select.
  localparam logic [7:0] SelBase        = 8'h40;
  // Two words per counter, low word first.
  localparam logic [7:0] CntBase        = 8'h80;

  typedef enum logic [3:0] {
    Cycle         = 4'd0,
    TcdmAccessed  = 4'd1,
    TcdmCongested = 4'd2,
    RetiredInstr  = 4'd3,
    RetiredLoad   = 4'd4,
    IssueFpu      = 4'd5,
    DmaBusy       = 4'd6,
    DmaRDone      = 4'd7,
    DmaRBytes     = 4'd8,
    IcacheMiss    = 4'd9,
    IcacheHit     = 4'd10
  } perf_metric_e;

  // Metrics tracked right after reset by the lowest counters.
  localparam int unsigned NumRstMetrics = 5;
  localparam perf_metric_e MetricRstTable [NumRstMetrics] = '{
    Cycle, RetiredInstr, TcdmAccessed, IcacheMiss, IcacheHit
  };

  typedef struct packed {
    logic retired_instr;
    logic retired_load;
    logic issue_fpu;
    // From the core's L0 instruction cache.
    logic l0_miss;
    logic l0_hit;
  } core_events_t;

  typedef struct packed {
    logic        tcdm_accessed;
    logic        tcdm_congested;
    logic        dma_busy;
    logic        dma_r_done;
    logic [15:0] dma_r_bytes;
  } cluster_events_t;

  typedef struct packed {
    logic       busy;
    logic       r_done;
    logic [7:0] r_len;
    logic [2:0] r_size;
  } dma_events_t;

  typedef struct packed {
    logic accessed;
    logic congested;
  } tcdm_events_t;

  typedef struct packed {
    logic        valid;
    logic        write;
    logic [7:0]  addr;
    logic [31:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic        valid;
    logic        error;
    logic [31:0] rdata;
  } reg_rsp_t;

  typedef struct packed {
    logic [19:0] reserved;
    logic [3:0]  metric;
    logic [7:0]  hart;
  } cnt_sel_t;

  // A bus word, either raw or as a counter select.
  typedef union packed {
    logic [31:0] raw;
    cnt_sel_t    sel;
  } reg_wdata_u;

endpackage

`default_nettype wire

//--- perf_event_stage.sv
/*
  Registers every event source once, so events reach the counters one cycle late.
  DMA read bytes assume (r_len + 1) << r_size fits in 16 bits.
*/
`timescale 1ns/1ps
`default_nettype none

module perf_event_stage
  import cluster_periph_pkg::*;
#(
  parameter int unsigned NrCores = 4
) (
  input  wire logic                       clk_i,
  input  wire logic                       reset_i,
  input  tcdm_events_t                    tcdm_events_i,
  input  dma_events_t                     dma_events_i,
  input  core_events_t [NrCores-1:0]      core_events_i,
  output cluster_events_t                 cluster_events_o,
  output core_events_t [NrCores-1:0]      core_events_o
);

  cluster_events_t            cluster_d, cluster_q;
  core_events_t [NrCores-1:0] core_q;
  logic [15:0]                r_bytes;

  // Bytes moved by one DMA read beat.
  always_comb begin
    r_bytes = '0;
    if (dma_events_i.r_done) begin
      r_bytes = (16'(dma_events_i.r_len) + 16'd1) << dma_events_i.r_size;
    end
  end

  always_comb begin
    cluster_d.tcdm_accessed  = tcdm_events_i.accessed;
    cluster_d.tcdm_congested = tcdm_events_i.congested;
    cluster_d.dma_busy       = dma_events_i.busy;
    cluster_d.dma_r_done     = dma_events_i.r_done;
    cluster_d.dma_r_bytes    = r_bytes;
  end

  // Event register stage.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cluster_q <= '0;
      core_q    <= '0;
    end else begin
      cluster_q <= cluster_d;
      core_q    <= core_events_i;
    end
  end

  assign cluster_events_o = cluster_q;
  assign core_events_o    = core_q;

endmodule

`default_nettype wire

//--- perf_counter.sv
/*
  One 48-bit performance counter with its own metric and hart select.
  Clear wins over counting; metric codes above IcacheHit count nothing.
*/
`timescale 1ns/1ps
`default_nettype none

module perf_counter
  import cluster_periph_pkg::*;
#(
  parameter int unsigned  NrCores   = 4,
  parameter perf_metric_e RstMetric = Cycle
) (
  input  wire logic                  clk_i,
  input  wire logic                  reset_i,
  input  wire logic                  en_i,
  input  wire logic                  clear_i,
  input  wire logic                  sel_we_i,
  input  reg_wdata_u                 sel_i,
  input  cluster_events_t            cluster_events_i,
  input  core_events_t [NrCores-1:0] core_events_i,
  output logic [CntWidth-1:0]        count_o,
  output perf_metric_e               metric_o,
  output logic [7:0]                 hart_o
);

  localparam int unsigned HartW = (NrCores > 1) ? $clog2(NrCores) : 1;

  logic [CntWidth-1:0] count_q;
  perf_metric_e        metric_q;
  logic [HartW-1:0]    hart_q;
  core_events_t        hart_ev;
  logic [15:0]         inc;

  // Harts past NrCores-1 (non power of two) see no events.
  assign hart_ev = (int'(hart_q) < NrCores) ? core_events_i[hart_q] : '0;

  always_comb begin
    inc = '0;
    case (metric_q)
      Cycle:         inc = 16'd1;
      TcdmAccessed:  inc = 16'(cluster_events_i.tcdm_accessed);
      TcdmCongested: inc = 16'(cluster_events_i.tcdm_congested);
      RetiredInstr:  inc = 16'(hart_ev.retired_instr);
      RetiredLoad:   inc = 16'(hart_ev.retired_load);
      IssueFpu:      inc = 16'(hart_ev.issue_fpu);
      DmaBusy:       inc = 16'(cluster_events_i.dma_busy);
      DmaRDone:      inc = 16'(cluster_events_i.dma_r_done);
      DmaRBytes:     inc = cluster_events_i.dma_r_bytes;
      IcacheMiss:    inc = 16'(hart_ev.l0_miss);
      IcacheHit:     inc = 16'(hart_ev.l0_hit);
      default:       inc = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_q <= '0;
    end else if (clear_i) begin
      count_q <= '0;
    end else if (en_i) begin
      count_q <= count_q + CntWidth'(inc);
    end
  end

  // The hart select keeps only its low bits, so higher harts wrap.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      metric_q <= RstMetric;
      hart_q   <= '0;
    end else if (sel_we_i) begin
      metric_q <= perf_metric_e'(sel_i.sel.metric);
      hart_q   <= sel_i.sel.hart[HartW-1:0];
    end
  end

  assign count_o  = count_q;
  assign metric_o = metric_q;
  assign hart_o   = 8'(hart_q);

endmodule

`default_nettype wire

//--- cluster_periph_regs.sv
/*
  Register decoder; each request is answered exactly one cycle later.
  Reads return state from before the request edge. Set/clear words read 0.
  Assumes NrCores <= 32 and NumPerfCounters <= 8.
*/
`timescale 1ns/1ps
`default_nettype none

module cluster_periph_regs
  import cluster_periph_pkg::*;
#(
  parameter int unsigned NrCores         = 4,
  parameter int unsigned NumPerfCounters = 8
) (
  input  wire logic                                     clk_i,
  input  wire logic                                     reset_i,
  input  reg_req_t                                      reg_req_i,
  output reg_rsp_t                                      reg_rsp_o,
  input  wire logic [9:0]                               hart_base_id_i,
  output logic [NrCores-1:0]                            cl_clint_o,
  output logic                                          icache_prefetch_enable_o,
  output logic [NumPerfCounters-1:0]                    cnt_en_o,
  output logic [NumPerfCounters-1:0]                    cnt_clear_o,
  output logic [NumPerfCounters-1:0]                    sel_we_o,
  output reg_wdata_u                                    sel_o,
  input  wire logic [NumPerfCounters-1:0][CntWidth-1:0] count_i,
  input  perf_metric_e [NumPerfCounters-1:0]            metric_i,
  input  wire logic [NumPerfCounters-1:0][7:0]          hart_i
);

  logic [NumPerfCounters-1:0] en_d, en_q;
  logic [NrCores-1:0]         clint_d, clint_q;
  logic                       prefetch_d, prefetch_q;
  logic                       wr, hit, read_only;
  logic [31:0]                rdata_d, rsp_rdata_q;
  logic                       rsp_valid_q, rsp_err_q;

  assign wr = reg_req_i.valid & reg_req_i.write;

  always_comb begin
    reg_wdata_u rd_sel;
    hit         = 1'b0;
    read_only   = 1'b0;
    rdata_d     = '0;
    en_d        = en_q;
    clint_d     = clint_q;
    prefetch_d  = prefetch_q;
    cnt_clear_o = '0;
    sel_we_o    = '0;
    rd_sel.raw  = '0;
    case (reg_req_i.addr)
      EnAddr: begin
        hit     = 1'b1;
        rdata_d = 32'(en_q);
        if (wr) en_d = reg_req_i.wdata[NumPerfCounters-1:0];
      end
      ClintSetAddr: begin
        hit = 1'b1;
        if (wr) clint_d = clint_q | reg_req_i.wdata[NrCores-1:0];
      end
      ClintClearAddr: begin
        hit = 1'b1;
        if (wr) clint_d = clint_q & ~reg_req_i.wdata[NrCores-1:0];
      end
      ClintStateAddr: begin
        hit       = 1'b1;
        read_only = 1'b1;
        rdata_d   = 32'(clint_q);
      end
      PrefetchAddr: begin
        hit     = 1'b1;
        rdata_d = 32'(prefetch_q);
        if (wr) prefetch_d = reg_req_i.wdata[0];
      end
      HartBaseAddr: begin
        hit       = 1'b1;
        read_only = 1'b1;
        rdata_d   = 32'(hart_base_id_i);
      end
      default: ;
    endcase
    // Per-counter select and count words.
    for (int i = 0; i < NumPerfCounters; i++) begin
      if (reg_req_i.addr == SelBase + 8'(4 * i)) begin
        hit               = 1'b1;
        rd_sel.sel.metric = metric_i[i];
        rd_sel.sel.hart   = hart_i[i];
        rdata_d           = rd_sel.raw;
        sel_we_o[i]       = wr;
      end
      if (reg_req_i.addr == CntBase + 8'(8 * i)) begin
        hit            = 1'b1;
        rdata_d        = count_i[i][31:0];
        cnt_clear_o[i] = wr;
      end
      if (reg_req_i.addr == CntBase + 8'(8 * i + 4)) begin
        hit            = 1'b1;
        rdata_d        = 32'(count_i[i][CntWidth-1:32]);
        cnt_clear_o[i] = wr;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      en_q        <= '0;
      clint_q     <= '0;
      prefetch_q  <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      en_q        <= en_d;
      clint_q     <= clint_d;
      prefetch_q  <= prefetch_d;
      rsp_valid_q <= reg_req_i.valid;
    end
  end

  // Response error flag and read data.
  always_ff @(posedge clk_i) begin
    rsp_err_q   <= !hit || (wr && read_only);
    rsp_rdata_q <= rdata_d;
  end

  assign reg_rsp_o = '{valid: rsp_valid_q, error: rsp_err_q, rdata: rsp_rdata_q};

  assign cl_clint_o               = clint_q;
  assign icache_prefetch_enable_o = prefetch_q;
  assign cnt_en_o                 = en_q;
  assign sel_o.raw                = reg_req_i.wdata;

endmodule

`default_nettype wire

//--- cluster_peripheral.sv
/*
  Cluster peripheral top: event stage, counter bank and register block.
  NumPerfCounters must not exceed 8; events are counted two cycles after input.
*/
`timescale 1ns/1ps
`default_nettype none

module cluster_peripheral
  import cluster_periph_pkg::*;
#(
  parameter int unsigned NrCores         = 4,
  parameter int unsigned NumPerfCounters = 8
) (
  input  wire logic                  clk_i,
  input  wire logic                  reset_i,
  input  reg_req_t                   reg_req_i,
  output reg_rsp_t                   reg_rsp_o,
  input  wire logic [9:0]            hart_base_id_i,
  output logic [NrCores-1:0]         cl_clint_o,
  output logic                       icache_prefetch_enable_o,
  input  tcdm_events_t               tcdm_events_i,
  input  dma_events_t                dma_events_i,
  input  core_events_t [NrCores-1:0] core_events_i
);

  cluster_events_t                           cluster_ev;
  core_events_t [NrCores-1:0]                core_ev;
  logic [NumPerfCounters-1:0]                cnt_en, cnt_clear, sel_we;
  reg_wdata_u                                sel;
  logic [NumPerfCounters-1:0][CntWidth-1:0]  count;
  perf_metric_e [NumPerfCounters-1:0]        metric;
  logic [NumPerfCounters-1:0][7:0]           hart;

  perf_event_stage #(
    .NrCores (NrCores)
  ) i_event_stage (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .tcdm_events_i    (tcdm_events_i),
    .dma_events_i     (dma_events_i),
    .core_events_i    (core_events_i),
    .cluster_events_o (cluster_ev),
    .core_events_o    (core_ev)
  );

  for (genvar i = 0; i < NumPerfCounters; i++) begin : gen_cnt
    // Counters beyond the table start out on Cycle.
    localparam perf_metric_e RstMetric =
      (i < NumRstMetrics) ? MetricRstTable[i % NumRstMetrics] : Cycle;

    perf_counter #(
      .NrCores   (NrCores),
      .RstMetric (RstMetric)
    ) i_cnt (
      .clk_i            (clk_i),
      .reset_i          (reset_i),
      .en_i             (cnt_en[i]),
      .clear_i          (cnt_clear[i]),
      .sel_we_i         (sel_we[i]),
      .sel_i            (sel),
      .cluster_events_i (cluster_ev),
      .core_events_i    (core_ev),
      .count_o          (count[i]),
      .metric_o         (metric[i]),
      .hart_o           (hart[i])
    );
  end

  cluster_periph_regs #(
    .NrCores         (NrCores),
    .NumPerfCounters (NumPerfCounters)
  ) i_regs (
    .clk_i                    (clk_i),
    .reset_i                  (reset_i),
    .reg_req_i                (reg_req_i),
    .reg_rsp_o                (reg_rsp_o),
    .hart_base_id_i           (hart_base_id_i),
    .cl_clint_o               (cl_clint_o),
    .icache_prefetch_enable_o (icache_prefetch_enable_o),
    .cnt_en_o                 (cnt_en),
    .cnt_clear_o              (cnt_clear),
    .sel_we_o                 (sel_we),
    .sel_o                    (sel),
    .count_i                  (count),
    .metric_i                 (metric),
    .hart_i                   (hart)
  );

endmodule

`default_nettype wire

//--- cluster_peripheral_sva.sv
/*
  Bus timing and reset checks, bound into every cluster_periph_regs instance.
  One request at a time is assumed per cycle.
*/
`timescale 1ns/1ps
`default_nettype none

module cluster_peripheral_sva
  import cluster_periph_pkg::*;
#(
  parameter int unsigned NrCores         = 4,
  parameter int unsigned NumPerfCounters = 8
) (
  input wire logic                       clk_i,
  input wire logic                       reset_i,
  input reg_req_t                        req_i,
  input reg_rsp_t                        rsp_i,
  input wire logic [NrCores-1:0]         clint_i,
  input wire logic                       prefetch_i,
  input wire logic [NumPerfCounters-1:0] cnt_en_i
);

  // Every request is answered on the next cycle.
  rsp_follows_req: assert property (@(posedge clk_i) disable iff (reset_i)
    req_i.valid |=> rsp_i.valid)
    else $error("Request was not answered on the next cycle.");

  // A response always has a request one cycle before it.
  no_rsp_without_req: assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_i.valid |-> $past(req_i.valid))
    else $error("Response appeared without a request.");

  // Reset leaves no response and clears the control state.
  reset_state: assert property (@(posedge clk_i)
    reset_i |=> !rsp_i.valid && clint_i == '0 && !prefetch_i && cnt_en_i == '0)
    else $error("Register state is not cleared by reset.");

endmodule

bind cluster_periph_regs cluster_peripheral_sva #(
  .NrCores         (NrCores),
  .NumPerfCounters (NumPerfCounters)
) i_sva (
  .clk_i      (clk_i),
  .reset_i    (reset_i),
  .req_i      (reg_req_i),
  .rsp_i      (reg_rsp_o),
  .clint_i    (cl_clint_o),
  .prefetch_i (icache_prefetch_enable_o),
  .cnt_en_i   (cnt_en_o)
);

`default_nettype wire

//--- tb_cluster_peripheral.sv
/*
  Testbench for the cluster peripheral with four cores and eight counters.
  Bus accesses are issued one at a time; random events use a fixed seed.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_cluster_peripheral
  import cluster_periph_pkg::*;
();

  localparam int unsigned NrCores         = 4;
  localparam int unsigned NumPerfCounters = 8;
  localparam int unsigned HartW           = $clog2(NrCores);
  localparam int unsigned NumRounds       = 3;
  localparam int unsigned EventCycles     = 40;
  // The full sequence takes roughly 500 cycles.
  localparam int unsigned TimeoutCycles   = 4000;
  localparam logic [9:0]  HartBase        = 10'h2A5;
  localparam perf_metric_e RstMetrics [NumPerfCounters] = '{
    Cycle, RetiredInstr, TcdmAccessed, IcacheMiss, IcacheHit, Cycle, Cycle, Cycle
  };

  typedef struct packed {
    tcdm_events_t               tcdm;
    dma_events_t                dma;
    core_events_t [NrCores-1:0] core;
  } ev_sample_t;

  typedef struct packed {
    logic        write;
    logic [7:0]  addr;
    logic        chk;
    logic [31:0] data;
    logic        err;
  } rsp_expect_t;

  logic                       clk;
  logic                       reset;
  reg_req_t                   reg_req;
  reg_rsp_t                   reg_rsp;
  logic [9:0]                 hart_base;
  logic [NrCores-1:0]         cl_clint;
  logic                       prefetch_en;
  tcdm_events_t               tcdm_ev;
  dma_events_t                dma_ev;
  core_events_t [NrCores-1:0] core_ev;

  rsp_expect_t  expect_q[$];
  ev_sample_t   samples[$];
  int unsigned  cyc, req_cyc, rsp_count, checks, errors;
  logic [31:0]  last_rdata;
  integer       seed = 32'h9716;

  cluster_peripheral #(
    .NrCores         (NrCores),
    .NumPerfCounters (NumPerfCounters)
  ) dut0 (
    .clk_i                    (clk),
    .reset_i                  (reset),
    .reg_req_i                (reg_req),
    .reg_rsp_o                (reg_rsp),
    .hart_base_id_i           (hart_base),
    .cl_clint_o               (cl_clint),
    .icache_prefetch_enable_o (prefetch_en),
    .tcdm_events_i            (tcdm_ev),
    .dma_events_i             (dma_ev),
    .core_events_i            (core_ev)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= TimeoutCycles) begin
      $display("Timeout: the test did not finish within %0d cycles.", TimeoutCycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  task automatic flag_mismatch(input string msg);
    errors++;
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
  endtask

  // Per-cycle increment of one metric for one recorded event sample.
  function automatic logic [47:0] ref_inc(input perf_metric_e metric,
                                          input logic [HartW-1:0] hart, input ev_sample_t s);
    case (metric)
      Cycle:         return 48'd1;
      TcdmAccessed:  return 48'(s.tcdm.accessed);
      TcdmCongested: return 48'(s.tcdm.congested);
      RetiredInstr:  return 48'(s.core[hart].retired_instr);
      RetiredLoad:   return 48'(s.core[hart].retired_load);
      IssueFpu:      return 48'(s.core[hart].issue_fpu);
      DmaBusy:       return 48'(s.dma.busy);
      DmaRDone:      return 48'(s.dma.r_done);
      DmaRBytes:     return s.dma.r_done ?
                            (48'(s.dma.r_len) + 48'd1) * (48'd1 << s.dma.r_size) : 48'd0;
      IcacheMiss:    return 48'(s.core[hart].l0_miss);
      IcacheHit:     return 48'(s.core[hart].l0_hit);
      default:       return 48'd0;
    endcase
  endfunction

  // Cycle counts the enabled window and the other metrics sum over the random samples.
  function automatic logic [47:0] model_count(input perf_metric_e metric,
                                              input logic [HartW-1:0] hart,
                                              input int unsigned window);
    logic [47:0] sum;
    sum = '0;
    if (metric == Cycle) return 48'(window);
    foreach (samples[k]) sum += ref_inc(metric, hart, samples[k]);
    return sum;
  endfunction

  // Compares each response with the oldest pending expectation.
  always @(negedge clk) begin
    rsp_expect_t e;
    if (reg_rsp.valid) begin
      if (expect_q.size() == 0) begin
        errors++;
        $display("Error at %0t ns: a response arrived with no request pending.", $time);
      end else begin
        e = expect_q.pop_front();
        checks++;
        if (reg_rsp.error !== e.err)
          flag_mismatch($sformatf("%s 0x%02h: error %0b, expected %0b",
                                  e.write ? "write" : "read", e.addr, reg_rsp.error, e.err));
        if (e.chk && reg_rsp.rdata !== e.data)
          flag_mismatch($sformatf("read 0x%02h: rdata 0x%08h, expected 0x%08h",
                                  e.addr, reg_rsp.rdata, e.data));
      end
      last_rdata = reg_rsp.rdata;
      rsp_count++;
    end
  end

  task automatic bus_access(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
                            input logic chk, input logic [31:0] exp_data, input logic exp_err);
    int unsigned seen;
    seen = rsp_count;
    @(posedge clk);
    #1;
    expect_q.push_back('{write: write, addr: addr, chk: chk, data: exp_data, err: exp_err});
    req_cyc = cyc + 1;
    reg_req = '{valid: 1'b1, write: write, addr: addr, wdata: wdata};
    @(posedge clk);
    #1;
    reg_req = '0;
    wait (rsp_count != seen);
  endtask

  task automatic drive_events(input logic random_ev);
    ev_sample_t  s;
    logic [31:0] r0, r1;
    s = '0;
    if (random_ev) begin
      r0 = $random(seed);
      r1 = $random(seed);
      s.tcdm = r0[1:0];
      s.dma  = '{busy: r0[2], r_done: r0[3], r_len: r0[15:8], r_size: r0[18:16]};
      s.core = r1[5*NrCores-1:0];
    end
    @(posedge clk);
    #1;
    tcdm_ev = s.tcdm;
    dma_ev  = s.dma;
    core_ev = s.core;
    if (random_ev) samples.push_back(s);
  endtask

  initial begin
    logic [NrCores-1:0] clint_model;
    logic [31:0]        pat, first_rd;
    logic [47:0]        exp_cnt [NumPerfCounters];
    perf_metric_e       metric [NumPerfCounters];
    int unsigned        hart [NumPerfCounters];
    int unsigned        en_cyc, window;
    clk       = 1'b0;
    reset     = 1'b1;
    reg_req   = '0;
    hart_base = HartBase;
    tcdm_ev   = '0;
    dma_ev    = '0;
    core_ev   = '0;
    repeat (8) @(posedge clk);
    #1 reset = 1'b0;

    // Reset values of selects, counts and control registers.
    for (int i = 0; i < NumPerfCounters; i++) begin
      bus_access(1'b0, SelBase + 8'(4 * i), '0, 1'b1, {20'd0, RstMetrics[i], 8'd0}, 1'b0);
      bus_access(1'b0, CntBase + 8'(8 * i), '0, 1'b1, 32'd0, 1'b0);
      bus_access(1'b0, CntBase + 8'(8 * i + 4), '0, 1'b1, 32'd0, 1'b0);
    end
    bus_access(1'b0, EnAddr, '0, 1'b1, 32'd0, 1'b0);
    bus_access(1'b0, ClintStateAddr, '0, 1'b1, 32'd0, 1'b0);
    bus_access(1'b0, PrefetchAddr, '0, 1'b1, 32'd0, 1'b0);
    bus_access(1'b0, HartBaseAddr, '0, 1'b1, {22'd0, HartBase}, 1'b0);

    // Wake-up bits through alternating set and clear writes.
    clint_model = '0;
    for (int k = 0; k < 8; k++) begin
      pat = $random(seed);
      if (k % 2 == 0) begin
        bus_access(1'b1, ClintSetAddr, pat, 1'b0, '0, 1'b0);
        clint_model = clint_model | pat[NrCores-1:0];
      end else begin
        bus_access(1'b1, ClintClearAddr, pat, 1'b0, '0, 1'b0);
        clint_model = clint_model & ~pat[NrCores-1:0];
      end
      checks++;
      if (cl_clint !== clint_model)
        flag_mismatch($sformatf("cl_clint_o %b, expected %b", cl_clint, clint_model));
      bus_access(1'b0, ClintStateAddr, '0, 1'b1, 32'(clint_model), 1'b0);
    end
    for (int b = 1; b >= 0; b--) begin
      bus_access(1'b1, PrefetchAddr, 32'(b), 1'b0, '0, 1'b0);
      checks++;
      if (prefetch_en !== 1'(b))
        flag_mismatch($sformatf("prefetch enable %b, expected %0d", prefetch_en, b));
      bus_access(1'b0, PrefetchAddr, '0, 1'b1, 32'(b), 1'b0);
    end

    // Counting rounds; events are zero before and after each random window.
    for (int r = 0; r < NumRounds; r++) begin
      for (int i = 0; i < NumPerfCounters; i++) begin
        metric[i] = perf_metric_e'((r * 8 + i) % 11);
        hart[i]   = i + 3 * r;
        bus_access(1'b1, SelBase + 8'(4 * i), {20'd0, metric[i], 8'(hart[i])}, 1'b0, '0, 1'b0);
        bus_access(1'b0, SelBase + 8'(4 * i), '0, 1'b1,
                   {20'd0, metric[i], 8'(hart[i] % NrCores)}, 1'b0);
        bus_access(1'b1, CntBase + 8'(8 * i), '0, 1'b0, '0, 1'b0);
      end
      bus_access(1'b1, EnAddr, 32'(2 ** NumPerfCounters - 1), 1'b0, '0, 1'b0);
      en_cyc = req_cyc;
      samples.delete();
      repeat (EventCycles) drive_events(1'b1);
      drive_events(1'b0);
      repeat (4) @(posedge clk);
      bus_access(1'b1, EnAddr, '0, 1'b0, '0, 1'b0);
      window = req_cyc - en_cyc;
      for (int i = 0; i < NumPerfCounters; i++) begin
        exp_cnt[i] = model_count(metric[i], HartW'(hart[i] % NrCores), window);
        bus_access(1'b0, CntBase + 8'(8 * i), '0, 1'b1, exp_cnt[i][31:0], 1'b0);
        bus_access(1'b0, CntBase + 8'(8 * i + 4), '0, 1'b1, 32'(exp_cnt[i][47:32]), 1'b0);
      end
    end

    // Counter 6 counts cycles in the last round and is now disabled.
    bus_access(1'b0, CntBase + 8'd48, '0, 1'b1, exp_cnt[6][31:0], 1'b0);
    first_rd = last_rdata;
    repeat (5) @(posedge clk);
    bus_access(1'b0, CntBase + 8'd48, '0, 1'b1, exp_cnt[6][31:0], 1'b0);
    checks++;
    if (last_rdata !== first_rd)
      flag_mismatch($sformatf("disabled counter moved from %0d to %0d", first_rd, last_rdata));
    bus_access(1'b1, CntBase + 8'd52, 32'h1234, 1'b0, '0, 1'b0);
    bus_access(1'b0, CntBase + 8'd48, '0, 1'b1, 32'd0, 1'b0);
    bus_access(1'b0, CntBase + 8'd52, '0, 1'b1, 32'd0, 1'b0);

    // Unmapped and read-only addresses.
    bus_access(1'b0, 8'h3C, '0, 1'b1, 32'd0, 1'b1);
    bus_access(1'b0, 8'h60, '0, 1'b1, 32'd0, 1'b1);
    bus_access(1'b1, HartBaseAddr, 32'h155, 1'b0, '0, 1'b1);
    bus_access(1'b0, HartBaseAddr, '0, 1'b1, {22'd0, HartBase}, 1'b0);
    bus_access(1'b1, ClintStateAddr, 32'hF, 1'b0, '0, 1'b1);
    bus_access(1'b0, ClintStateAddr, '0, 1'b1, 32'(clint_model), 1'b0);

    repeat (2) @(posedge clk);
    if (expect_q.size() != 0) begin
      errors++;
      $display("Error: %0d requests never got a response.", expect_q.size());
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
cluster_periph_pkg.sv
perf_event_stage.sv
perf_counter.sv
cluster_periph_regs.sv
cluster_peripheral.sv
cluster_peripheral_sva.sv
tb_cluster_peripheral.sv

//--- Makefile
# Verilator build and run for the cluster peripheral.
# Any variable can be overridden, e.g. make LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_cluster_peripheral
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "Simulation passed."; \
	else \
		echo "Simulation failed, see $(LOG)."; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
